// File: gf_coprocessor.f
+incdir+hdl
hdl/gf_pkg.sv
hdl/gf_standard_multiplier.sv
hdl/gf_power.sv
hdl/gf_divider.sv
hdl/gf_alu.sv
hdl/gf_axil_regs.sv
hdl/gf_coprocessor.sv
sim/gf_coprocessor_tb.sv

// File: Makefile
TOP = gf_coprocessor_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f gf_coprocessor.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: sim/gf_coprocessor_tb.sv
`include "gf_defs.svh"

module gf_coprocessor_tb;

	localparam int FW = `GF_M;

	// about 700 bus transactions of ten cycles or so, with a wide margin.
	localparam int CYCLE_LIMIT = 20000;

	logic clk;
	logic reset;
	logic [`GF_AXI_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [`GF_AXI_DATA_W-1:0] wdata;
	logic [`GF_AXI_DATA_W/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [`GF_AXI_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [`GF_AXI_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	integer seed;
	int cycle_count;
	logic [31:0] rd;
	logic [31:0] status;
	logic [1:0] resp;
	logic saw_busy;
	logic [FW-1:0] a;
	logic [FW-1:0] b;
	logic [FW-1:0] q;
	gf_pkg::gf_op_e op_sel;

	gf_coprocessor u_dut (.*);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count == CYCLE_LIMIT)
			fail_run("timeout, the run did not finish within the cycle limit");
	end

	// ****************************************
	// reference field model
	// ****************************************

	function automatic logic [FW-1:0] add_ref(input logic [FW-1:0] x, input logic [FW-1:0] y);
		return x ^ y;
	endfunction

	// shift and add, reducing by the field polynomial at each shift.
	function automatic logic [FW-1:0] mul_ref(input logic [FW-1:0] x, input logic [FW-1:0] y);
		logic [FW-1:0] p;
		logic [FW-1:0] s;
		p = '0;
		s = x;
		for (int i = 0; i < FW; i++) begin
			if (y[i])
				p = p ^ s;
			s = {s[FW-2:0], 1'b0} ^ (s[FW-1] ? `GF_POLY : '0);
		end
		return p;
	endfunction

	function automatic logic [FW-1:0] inv_ref(input logic [FW-1:0] d);
		logic [FW-1:0] x;
		x = '0;
		for (int i = 1; i < (1 << FW); i++) begin
			if (mul_ref(d, FW'(i)) == FW'(1))
				x = FW'(i);
		end
		return x;
	endfunction

	function automatic logic [FW-1:0] model_result(input gf_pkg::gf_op_e op,
			input logic [FW-1:0] x, input logic [FW-1:0] y);
		case (op)
			gf_pkg::OP_MUL: return mul_ref(x, y);
			gf_pkg::OP_SQR: return mul_ref(x, x);
			gf_pkg::OP_CUBE: return mul_ref(mul_ref(x, x), x);
			gf_pkg::OP_DIV: return mul_ref(x, inv_ref(y));
			default: return add_ref(x, y);
		endcase
	endfunction

	// ****************************************
	// checking
	// ****************************************

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else
			fail_run($sformatf("Error at time %0t: %s expected %h actual %h",
				$time, name, expected, actual));
	endtask

	// ****************************************
	// bus master, entered and left just after a falling edge
	// ****************************************

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] wr_resp);
		logic aw_go;
		logic w_go;
		int delay;
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		while (awvalid || wvalid) begin
			aw_go = awvalid && awready;
			w_go = wvalid && wready;
			@(negedge clk);
			if (aw_go)
				awvalid = 1'b0;
			if (w_go)
				wvalid = 1'b0;
		end
		while (!bvalid)
			@(negedge clk);
		wr_resp = bresp;
		delay = $random(seed) & 3;
		// response must hold while the master stalls.
		repeat (delay) begin
			@(negedge clk);
			check_value("bvalid", 32'd1, 32'(bvalid));
			check_value("bresp", 32'(wr_resp), 32'(bresp));
		end
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
		check_value("bvalid after handshake", 32'd0, 32'(bvalid));
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
		logic ar_go;
		int delay;
		araddr = addr;
		arvalid = 1'b1;
		while (arvalid) begin
			ar_go = arready;
			@(negedge clk);
			if (ar_go)
				arvalid = 1'b0;
		end
		while (!rvalid)
			@(negedge clk);
		data = rdata;
		check_value("rresp", 32'd0, 32'(rresp));
		delay = $random(seed) & 3;
		repeat (delay) begin
			@(negedge clk);
			check_value("rvalid", 32'd1, 32'(rvalid));
			check_value("rdata", data, rdata);
		end
		rready = 1'b1;
		@(negedge clk);
		rready = 0;
		check_value("rvalid after handshake", 32'd0, 32'(rvalid));
	endtask

	// reads STATUS until busy is low, noting whether busy was ever seen.
	task automatic poll_status(output logic [31:0] st, output logic busy_seen);
		busy_seen = 1'b0;
		read_reg(`GF_ADDR_STATUS, st);
		while (st[`GF_STATUS_BUSY]) begin
			busy_seen = 1'b1;
			read_reg(`GF_ADDR_STATUS, st);
		end
	endtask

	task automatic issue_op(input gf_pkg::gf_op_e op, output logic [31:0] st,
			output logic busy_seen);
		logic [1:0] wr_resp;
		write_reg(`GF_ADDR_CTRL, 32'(op), 4'hf, wr_resp);
		check_value("bresp ctrl", 32'd0, 32'(wr_resp));
		poll_status(st, busy_seen);
	endtask

	// ****************************************
	// test sequence
	// ****************************************

	initial begin
		seed = 32'he406cce8;
		cycle_count = 0;
		clk = 1'b0;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		// idle bus and cleared registers out of reset.
		check_value("awready", 32'd0, 32'(awready));
		check_value("wready", 32'd0, 32'(wready));
		check_value("arready", 32'd0, 32'(arready));
		check_value("bvalid", 32'd0, 32'(bvalid));
		check_value("rvalid", 32'd0, 32'(rvalid));
		for (int i = 0; i < 4; i++) begin
			read_reg(4'(4 * i), rd);
			check_value("reset readback", 32'd0, rd);
		end

		// operand read-back, and a write without byte 0 enabled.
		write_reg(`GF_ADDR_A, 32'h5a, 4'hf, resp);
		read_reg(`GF_ADDR_A, rd);
		check_value("reg a", 32'h5a, rd);
		write_reg(`GF_ADDR_B, 32'hc3, 4'hf, resp);
		read_reg(`GF_ADDR_B, rd);
		check_value("reg b", 32'hc3, rd);
		write_reg(`GF_ADDR_A, 32'hff, 4'he, resp);
		read_reg(`GF_ADDR_A, rd);
		check_value("reg a masked", 32'h5a, rd);

		// single-cycle operations.
		for (int n = 0; n < 40; n++) begin
			a = FW'($random(seed));
			b = FW'($random(seed));
			write_reg(`GF_ADDR_A, 32'(a), 4'hf, resp);
			write_reg(`GF_ADDR_B, 32'(b), 4'hf, resp);
			for (int k = 0; k < 4; k++) begin
				case (k)
					0: op_sel = gf_pkg::OP_ADD;
					1: op_sel = gf_pkg::OP_MUL;
					2: op_sel = gf_pkg::OP_SQR;
					default: op_sel = gf_pkg::OP_CUBE;
				endcase
				issue_op(op_sel, status, saw_busy);
				check_value("result", 32'(model_result(op_sel, a, b)), 32'(status[FW-1:0]));
				check_value("busy seen", 32'd0, 32'(saw_busy));
				check_value("div_zero", 32'd0, 32'(status[`GF_STATUS_DIVZERO]));
			end
		end

		// divide by nonzero divisors.
		for (int n = 0; n < 40; n++) begin
			a = FW'($random(seed));
			b = FW'($random(seed));
			if (b == '0)
				b = FW'(1);
			write_reg(`GF_ADDR_A, 32'(a), 4'hf, resp);
			write_reg(`GF_ADDR_B, 32'(b), 4'hf, resp);
			issue_op(gf_pkg::OP_DIV, status, saw_busy);
			q = status[FW-1:0];
			check_value("busy seen on divide", 32'd1, 32'(saw_busy));
			check_value("quotient", 32'(model_result(gf_pkg::OP_DIV, a, b)), 32'(q));
			check_value("quotient times b", 32'(a), 32'(mul_ref(q, b)));
			check_value("div_zero", 32'd0, 32'(status[`GF_STATUS_DIVZERO]));
		end

		// zero divisor, then a valid operation clears the flag.
		write_reg(`GF_ADDR_B, 32'h0, 4'hf, resp);
		issue_op(gf_pkg::OP_DIV, status, saw_busy);
		check_value("result zero div", 32'd0, 32'(status[FW-1:0]));
		check_value("div_zero set", 32'd1, 32'(status[`GF_STATUS_DIVZERO]));
		check_value("busy seen zero div", 32'd0, 32'(saw_busy));
		write_reg(`GF_ADDR_B, 32'h07, 4'hf, resp);
		issue_op(gf_pkg::OP_MUL, status, saw_busy);
		check_value("div_zero cleared", 32'd0, 32'(status[`GF_STATUS_DIVZERO]));
		check_value("result after clear", 32'(mul_ref(a, FW'(7))), 32'(status[FW-1:0]));

		// a command while the divider runs is refused.
		write_reg(`GF_ADDR_A, 32'h9e, 4'hf, resp);
		write_reg(`GF_ADDR_B, 32'h35, 4'hf, resp);
		write_reg(`GF_ADDR_CTRL, 32'(gf_pkg::OP_DIV), 4'hf, resp);
		check_value("bresp divide", 32'd0, 32'(resp));
		write_reg(`GF_ADDR_CTRL, 32'(gf_pkg::OP_ADD), 4'hf, resp);
		check_value("bresp while busy", 32'd2, 32'(resp));
		poll_status(status, saw_busy);
		check_value("quotient after refusal",
			32'(model_result(gf_pkg::OP_DIV, FW'(8'h9e), FW'(8'h35))), 32'(status[FW-1:0]));
		read_reg(`GF_ADDR_CTRL, rd);
		check_value("ctrl readback", 32'(gf_pkg::OP_DIV), rd);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: hdl/gf_coprocessor.sv
`include "gf_defs.svh"

module gf_coprocessor (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [`GF_AXI_ADDR_W-1:0]   awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [`GF_AXI_DATA_W-1:0]   wdata,
	input  logic [`GF_AXI_DATA_W/8-1:0] wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output logic [1:0]                  bresp,
	output logic                        bvalid,
	input  logic                        bready,
	input  logic [`GF_AXI_ADDR_W-1:0]   araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [`GF_AXI_DATA_W-1:0]   rdata,
	output logic [1:0]                  rresp,
	output logic                        rvalid,
	input  logic                        rready
);
	// command and result path between the slave and the alu.
	logic start;
	gf_pkg::gf_op_e op;
	logic [`GF_M-1:0] operand_a;
	logic [`GF_M-1:0] operand_b;
	logic busy;
	logic [`GF_M-1:0] result;
	logic div_zero;

	gf_axil_regs u_regs (.*);

	gf_alu u_alu (.*);

endmodule

// File: hdl/gf_axil_regs.sv
`include "gf_defs.svh"

module gf_axil_regs (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [`GF_AXI_ADDR_W-1:0]   awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [`GF_AXI_DATA_W-1:0]   wdata,
	input  logic [`GF_AXI_DATA_W/8-1:0] wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output logic [1:0]                  bresp,
	output logic                        bvalid,
	input  logic                        bready,
	input  logic [`GF_AXI_ADDR_W-1:0]   araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [`GF_AXI_DATA_W-1:0]   rdata,
	output logic [1:0]                  rresp,
	output logic                        rvalid,
	input  logic                        rready,
	output logic                        start,
	output gf_pkg::gf_op_e              op,
	output logic [`GF_M-1:0]            operand_a,
	output logic [`GF_M-1:0]            operand_b,
	input  logic                        busy,
	input  logic [`GF_M-1:0]            result,
	input  logic                        div_zero
);
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic aw_done;
	logic w_done;
	logic commit;
	logic [`GF_AXI_ADDR_W-1:0] aw_addr_q;
	logic [`GF_M-1:0] w_data_q;
	logic w_strb0_q;
	gf_pkg::gf_op_e new_op;
	logic [`GF_AXI_DATA_W-1:0] status_word;
	logic [`GF_AXI_DATA_W-1:0] read_word;

	// ****************************************
	// write channel
	// ****************************************

	// address and data are taken separately, one at a time.
	always_ff @(posedge clk) begin
		if (reset) begin
			awready <= 1'b0;
			wready <= 1'b0;
			aw_done <= 1'b0;
			w_done <= 1'b0;
		end else begin
			awready <= awvalid && !awready && !aw_done && !bvalid;
			wready <= wvalid && !wready && !w_done && !bvalid;
			if (awvalid && awready)
				aw_done <= 1'b1;
			else if (commit)
				aw_done <= 1'b0;
			if (wvalid && wready)
				w_done <= 1'b1;
			else if (commit)
				w_done <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (awvalid && awready)
			aw_addr_q <= awaddr;
		if (wvalid && wready) begin
			w_data_q <= wdata[`GF_M-1:0];
			w_strb0_q <= wstrb[0];
		end
	end

	assign commit = aw_done && w_done;

	// opcodes past OP_DIV fall back to add.
	always_comb begin
		case (w_data_q[2:0])
			3'd1: new_op = gf_pkg::OP_MUL;
			3'd2: new_op = gf_pkg::OP_SQR;
			3'd3: new_op = gf_pkg::OP_CUBE;
			3'd4: new_op = gf_pkg::OP_DIV;
			default: new_op = gf_pkg::OP_ADD;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bvalid <= 1'b0;
			bresp <= RESP_OKAY;
			start <= 1'b0;
			op <= gf_pkg::OP_ADD;
			operand_a <= '0;
			operand_b <= '0;
		end else begin
			start <= 1'b0;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (commit) begin
				bvalid <= 1'b1;
				bresp <= RESP_OKAY;
				case (aw_addr_q)
					`GF_ADDR_A: if (w_strb0_q) operand_a <= w_data_q;
					`GF_ADDR_B: if (w_strb0_q) operand_b <= w_data_q;
					`GF_ADDR_CTRL: begin
						// a busy alu drops the command.
						if (busy) begin
							bresp <= RESP_SLVERR;
						end else if (w_strb0_q) begin
							start <= 1'b1;
							op <= new_op;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// ****************************************
	// read channel
	// ****************************************

	always_comb begin
		status_word = '0;
		status_word[`GF_M-1:0] = result;
		status_word[`GF_STATUS_BUSY] = busy;
		status_word[`GF_STATUS_DIVZERO] = div_zero;
	end

	always_comb begin
		read_word = '0;
		case (araddr)
			`GF_ADDR_A: read_word[`GF_M-1:0] = operand_a;
			`GF_ADDR_B: read_word[`GF_M-1:0] = operand_b;
			`GF_ADDR_CTRL: read_word[2:0] = op;
			`GF_ADDR_STATUS: read_word = status_word;
			default: read_word = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (arvalid && arready)
				rvalid <= 1'b1;
			else if (rvalid && rready)
				rvalid <= 1'b0;
		end
	end

	// data is sampled once, at the address handshake.
	always_ff @(posedge clk) begin
		if (arvalid && arready)
			rdata <= read_word;
	end

	assign rresp = RESP_OKAY;

endmodule

// File: hdl/gf_alu.sv
`include "gf_defs.svh"

module gf_alu (
	input  logic             clk,
	input  logic             reset,
	input  logic             start,
	input  gf_pkg::gf_op_e   op,
	input  logic [`GF_M-1:0] operand_a,
	input  logic [`GF_M-1:0] operand_b,
	output logic             busy,
	output logic [`GF_M-1:0] result,
	output logic             div_zero
);
	gf_pkg::alu_state_e state;
	logic [`GF_M-1:0] product;
	logic [`GF_M-1:0] square;
	logic [`GF_M-1:0] cube;
	logic [`GF_M-1:0] quotient;
	logic b_zero;
	logic div_start;
	logic div_done;

	assign b_zero = (operand_b == '0);
	assign busy = (state == gf_pkg::ST_DIV);

	// a zero divisor never reaches the divider.
	assign div_start = start && (state == gf_pkg::ST_IDLE) &&
		(op == gf_pkg::OP_DIV) && !b_zero;

	gf_standard_multiplier u_mul (
		.a       (operand_a),
		.b       (operand_b),
		.product (product)
	);

	gf_power u_pow (
		.value  (operand_a),
		.square (square),
		.cube   (cube)
	);

	gf_divider u_div (
		.clk         (clk),
		.reset       (reset),
		.start       (div_start),
		.numerator   (operand_a),
		.denominator (operand_b),
		.quotient    (quotient),
		.done        (div_done)
	);

	// ****************************************
	// sequencer
	// ****************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= gf_pkg::ST_IDLE;
			result <= '0;
			div_zero <= 1'b0;
		end else begin
			case (state)
				gf_pkg::ST_IDLE: begin
					if (start) begin
						div_zero <= 1'b0;
						case (op)
							gf_pkg::OP_MUL: result <= product;
							gf_pkg::OP_SQR: result <= square;
							gf_pkg::OP_CUBE: result <= cube;
							gf_pkg::OP_DIV: begin
								if (b_zero) begin
									result <= '0;
									div_zero <= 1'b1;
								end else begin
									state <= gf_pkg::ST_DIV;
								end
							end
							// add, also the fallback.
							default: result <= operand_a ^ operand_b;
						endcase
					end
				end
				gf_pkg::ST_DIV: begin
					// result keeps the old value until the quotient lands.
					if (div_done) begin
						result <= quotient;
						state <= gf_pkg::ST_IDLE;
					end
				end
				default: state <= gf_pkg::ST_IDLE;
			endcase
		end
	end

endmodule

// File: hdl/gf_divider.sv
`include "gf_defs.svh"

module gf_divider (
	input  logic             clk,
	input  logic             reset,
	input  logic             start,
	input  logic [`GF_M-1:0] numerator,
	input  logic [`GF_M-1:0] denominator,
	output logic [`GF_M-1:0] quotient,
	output logic             done
);
	localparam int CNT_W = $clog2(`GF_M);

	// m-1 multiply steps are counted 0 .. m-2.
	localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`GF_M - 2);

	logic [`GF_M-1:0] acc;
	logic [`GF_M-1:0] power;
	logic [`GF_M-1:0] sq_in;
	logic [`GF_M-1:0] sq_out;
	logic [`GF_M-1:0] acc_next;
	logic running;
	logic [CNT_W-1:0] count;

	// the squarer sees the fresh denominator on start.
	assign sq_in = start ? denominator : power;

	gf_power u_sq (
		.value  (sq_in),
		.square (sq_out),
		.cube   ()
	);

	gf_standard_multiplier u_mul (
		.a       (acc),
		.b       (power),
		.product (acc_next)
	);

	// ****************************************
	// step control
	// ****************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			count <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				running <= 1'b1;
				count <= '0;
			end else if (running) begin
				count <= count + CNT_W'(1);
				if (count == LAST_STEP) begin
					running <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// ****************************************
	// fermat accumulation
	// ****************************************

	// n * d^-1 = n * d^2 * d^4 * ... * d^(2^(m-1)).
	always_ff @(posedge clk) begin
		if (start) begin
			power <= sq_out;
			acc <= numerator;
		end else if (running) begin
			power <= sq_out;
			acc <= acc_next;
		end
	end

	// held after the last step until the next start.
	assign quotient = acc;

endmodule

// File: hdl/gf_power.sv
`include "gf_defs.svh"

module gf_power (
	input  logic [`GF_M-1:0] value,
	output logic [`GF_M-1:0] square,
	output logic [`GF_M-1:0] cube
);
	// pairs[k] = value[p] & value[q] for p < q, with p = k / m and q = k % m.
	logic [`GF_M*`GF_M-1:0] pairs;

	for (genvar k = 0; k < `GF_M*`GF_M; k++) begin : g_pair
		localparam int P = k / `GF_M;
		localparam int Q = k % `GF_M;
		if (P < Q) begin : g_used
			assign pairs[k] = value[P] & value[Q];
		end else begin : g_unused
			assign pairs[k] = 1'b0;
		end
	end

	// ****************************************
	// one output bit per iteration
	// ****************************************

	for (genvar i = 0; i < `GF_M; i++) begin : g_out
		logic [`GF_M-1:0] sq_row;
		logic [`GF_M-1:0] lin_row;
		logic [`GF_M*`GF_M-1:0] cross_row;

		// bit i of alpha^(2j) and alpha^(3j).
		for (genvar j = 0; j < `GF_M; j++) begin : g_col
			localparam logic [`GF_M-1:0] SQ_TERM = gf_pkg::gf_alpha_pow(2 * j);
			localparam logic [`GF_M-1:0] LIN_TERM = gf_pkg::gf_alpha_pow(3 * j);
			assign sq_row[j] = SQ_TERM[i];
			assign lin_row[j] = LIN_TERM[i];
		end

		// cross weight is alpha^(2p+q) + alpha^(2q+p).
		for (genvar k = 0; k < `GF_M*`GF_M; k++) begin : g_cross
			localparam int P = k / `GF_M;
			localparam int Q = k % `GF_M;
			localparam logic [`GF_M-1:0] X_TERM = (P < Q) ?
				(gf_pkg::gf_alpha_pow(2 * P + Q) ^ gf_pkg::gf_alpha_pow(2 * Q + P)) : '0;
			assign cross_row[k] = X_TERM[i];
		end

		assign square[i] = ^(value & sq_row);
		assign cube[i] = (^(value & lin_row)) ^ (^(pairs & cross_row));
	end

endmodule

// File: hdl/gf_standard_multiplier.sv
`include "gf_defs.svh"

module gf_standard_multiplier (
	input  logic [`GF_M-1:0] a,
	input  logic [`GF_M-1:0] b,
	output logic [`GF_M-1:0] product
);
	// running copy of a * alpha^i.
	logic [`GF_M-1:0] row;

	// each bit of b selects one reduced shift of a.
	// the selected rows are summed mod 2.
	always_comb begin
		row = a;
		product = '0;
		for (int i = 0; i < `GF_M; i++) begin
			if (b[i]) begin
				product = product ^ row;
			end
			row = gf_pkg::gf_mul_alpha(row);
		end
	end

endmodule

// File: hdl/gf_pkg.sv
`include "gf_defs.svh"

package gf_pkg;

	// opcodes as written to CTRL bits [2:0].
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_MUL  = 3'd1,
		OP_SQR  = 3'd2,
		OP_CUBE = 3'd3,
		OP_DIV  = 3'd4
	} gf_op_e;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_DIV  = 2'd1
	} alu_state_e;

	// one step of the field lfsr, x * alpha.
	function automatic logic [`GF_M-1:0] gf_mul_alpha(input logic [`GF_M-1:0] x);
		return {x[`GF_M-2:0], 1'b0} ^ ({`GF_M{x[`GF_M-1]}} & `GF_POLY);
	endfunction

	// alpha^k in the standard basis, evaluated at elaboration.
	function automatic logic [`GF_M-1:0] gf_alpha_pow(input int k);
		logic [`GF_M-1:0] acc;
		acc = '0;
		acc[0] = 1'b1;
		for (int i = 0; i < k; i++) begin
			acc = gf_mul_alpha(acc);
		end
		return acc;
	endfunction

endpackage

// File: hdl/gf_defs.svh
`ifndef GF_DEFS_SVH
`define GF_DEFS_SVH

// ****************************************
// field
// ****************************************

// width of one field element.
`define GF_M 8

// x^8 + x^4 + x^3 + x^2 + 1 without the leading term.
`define GF_POLY 8'h1d

// ****************************************
// bus and register map
// ****************************************

`define GF_AXI_ADDR_W 4
`define GF_AXI_DATA_W 32

`define GF_ADDR_A      4'h0
`define GF_ADDR_B      4'h4
`define GF_ADDR_CTRL   4'h8
`define GF_ADDR_STATUS 4'hc

// status word bit positions.
`define GF_STATUS_BUSY    31
`define GF_STATUS_DIVZERO 30

`endif
